// File: src.f
rtl/spi_pkg.sv
rtl/spi_cfg_regs.sv
rtl/spi_tx_queue.sv
rtl/spi_byte_engine.sv
rtl/spi_rx_return.sv
rtl/spi_master_top.sv
sim/spi_slave_model.sv
sim/spi_master_checker.sv
sim/tb_spi_master.sv

// File: sim/tb_spi_master.sv
`timescale 1ns/1ns

module tb_spi_master;

    localparam int TX_DEPTH   = 4;
    localparam int RX_CREDITS = 2;
    localparam int TIMEOUT    = 20 * 16 * 9 + 1000;   // 20 bytes at worst pace plus margin

    logic           clk;
    logic           rst;
    logic           tx_valid;
    spi_pkg::byte_t tx_data;
    logic           tx_credit;
    logic           rx_valid;
    spi_pkg::byte_t rx_data;
    logic           rx_credit;
    logic           cfg_we;
    logic           cfg_addr;
    spi_pkg::byte_t cfg_wdata;
    spi_pkg::byte_t cfg_rdata;
    logic           sclk;
    logic           mosi;
    logic           miso;
    logic           ss;

    integer         seed;
    spi_pkg::byte_t sent_q[$];         // Score queue of pushed bytes
    int tx_cred      = TX_DEPTH;       // Host transmit credits
    int credit_seen  = 0;              // tx_credit pulses counted
    int rx_n         = 0;              // rx_valid strobes seen
    int credit_req   = 0;              // Manual receive credits to return
    logic auto_credit = 1'b1;          // Free each received slot at once
    int cur_div      = 0;              // Divider last written
    int ss_falls     = 0;
    int cycles       = 0;
    int run          = 0;              // Length of the current SCLK level
    int rises        = 0;              // SCLK rises within the byte modulo 8
    logic prev_sclk  = 1'b1;
    logic prev_ss    = 1'b1;

    spi_master_top #(.TX_DEPTH(TX_DEPTH), .RX_CREDITS(RX_CREDITS)) dut (
        .clk(clk), .rst(rst), .tx_valid(tx_valid), .tx_data(tx_data), .tx_credit(tx_credit),
        .rx_valid(rx_valid), .rx_data(rx_data), .rx_credit(rx_credit), .cfg_we(cfg_we),
        .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
        .sclk(sclk), .mosi(mosi), .miso(miso), .ss(ss)
    );

    spi_slave_model slave (.sclk(sclk), .mosi(mosi), .ss(ss), .miso(miso));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_sim(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input int exp, input int act);
        abort_sim($sformatf("Error at %0t ns: %s expected %0h, got %0h",
                            $time, name, exp, act));
    endtask

    // Host push that waits for a transmit credit first
    task automatic push_byte(input spi_pkg::byte_t b);
        while (tx_cred == 0) @(negedge clk);
        tx_valid = 1'b1;
        tx_data  = b;
        tx_cred--;
        sent_q.push_back(b);
        @(negedge clk);
        tx_valid = 1'b0;
    endtask

    task automatic write_cfg(input logic addr, input spi_pkg::byte_t val);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = val;
        @(negedge clk);
        cfg_we = 1'b0;
        if (!addr) cur_div = val;
        assert (cfg_rdata == (addr ? {7'b0, val[0]} : val))
            else report_mismatch("cfg_rdata", addr ? val[0] : val, cfg_rdata);
    endtask

    // Wait until all credits are back, every reply is in and SS is released
    task automatic wait_drained();
        while (!(ss && tx_cred == TX_DEPTH && rx_n == sent_q.size())) @(negedge clk);
    endtask

    task automatic check_mosi_bytes();
        assert (slave.got_q.size() == sent_q.size())
            else report_mismatch("slave byte count", sent_q.size(), slave.got_q.size());
        foreach (sent_q[i]) begin
            assert (slave.got_q[i] == sent_q[i])
                else report_mismatch($sformatf("mosi byte %0d", i), sent_q[i], slave.got_q[i]);
        end
    endtask

    task automatic run_bytes(input int n, input int exp_falls);
        int falls0;
        falls0 = ss_falls;
        repeat (n) push_byte(spi_pkg::byte_t'($random(seed)));
        wait_drained();
        assert (ss_falls - falls0 == exp_falls)
            else report_mismatch("ss falls", exp_falls, ss_falls - falls0);
        check_mosi_bytes();
    endtask

    // SS must stay high and nothing more may arrive
    task automatic hold_window(input int exp_rx);
        repeat (100) begin
            @(negedge clk);
            assert (ss) else report_mismatch("ss", 1, ss);
            assert (rx_n == exp_rx) else report_mismatch("rx_valid count", exp_rx, rx_n);
        end
    endtask

    task automatic run_backpressure();
        int base;
        base        = rx_n;
        auto_credit = 1'b0;
        repeat (4) push_byte(spi_pkg::byte_t'($random(seed)));
        while (rx_n < base + RX_CREDITS) @(negedge clk);
        while (!ss) @(negedge clk);
        hold_window(base + RX_CREDITS);
        credit_req = 1;                // Free one slot to release one byte
        while (rx_n < base + RX_CREDITS + 1) @(negedge clk);
        while (!ss) @(negedge clk);
        hold_window(base + RX_CREDITS + 1);
        credit_req  = RX_CREDITS;      // Free every held slot
        auto_credit = 1'b1;
        wait_drained();
        check_mosi_bytes();
    endtask

    // Host side monitor sampled on the falling edge
    always @(negedge clk) begin
        if (tx_credit) begin
            tx_cred++;
            credit_seen++;
        end
        assert (tx_cred <= TX_DEPTH) else report_mismatch("host tx credits", TX_DEPTH, tx_cred);
        if (rx_valid) begin
            assert (rx_data == spi_pkg::byte_t'(8'hA5 + rx_n))
                else report_mismatch("rx_data", spi_pkg::byte_t'(8'hA5 + rx_n), rx_data);
            rx_n++;
        end
        if (auto_credit && rx_valid) begin
            rx_credit = 1'b1;
        end else if (credit_req > 0) begin
            rx_credit = 1'b1;
            credit_req--;
        end else begin
            rx_credit = 1'b0;
        end
        assert (dut.chk.err_cnt == 0)
            else abort_sim("A timing assertion in the checker failed");
    end

    // SCLK phase lengths and SS falls
    always @(negedge clk) begin
        if (!rst) begin
            if (sclk != prev_sclk) begin
                if (sclk) begin        // Low phase just ended
                    assert (run == cur_div + 1)
                        else report_mismatch("sclk low cycles", cur_div + 1, run);
                    rises = (rises + 1) % 8;
                end else if (rises != 0) begin   // High phase between two bits
                    assert (run == cur_div + 1)
                        else report_mismatch("sclk high cycles", cur_div + 1, run);
                end
                run = 1;
            end else begin
                run++;
            end
            if (prev_ss && !ss) begin
                ss_falls++;
                rises = 0;
            end
        end
        prev_sclk = sclk;
        prev_ss   = ss;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) abort_sim("Timeout: the SPI traffic did not finish in time");
    end

    initial begin
        seed      = 48423;
        rst       = 1'b1;
        tx_valid  = 1'b0;
        tx_data   = '0;
        rx_credit = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = 1'b0;
        cfg_wdata = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (ss) else report_mismatch("ss", 1, ss);
        assert (sclk) else report_mismatch("sclk", 1, sclk);
        assert (!mosi) else report_mismatch("mosi", 0, mosi);
        assert (!tx_credit) else report_mismatch("tx_credit", 0, tx_credit);
        assert (!rx_valid) else report_mismatch("rx_valid", 0, rx_valid);
        assert (cfg_rdata == 8'h00) else report_mismatch("cfg_rdata addr 0", 0, cfg_rdata);
        cfg_addr = 1'b1;
        @(negedge clk);
        assert (cfg_rdata == 8'h00) else report_mismatch("cfg_rdata addr 1", 0, cfg_rdata);

        write_cfg(1'b0, 8'd0);         // Fastest SCLK with one byte per select
        run_bytes(4, 4);
        write_cfg(1'b0, 8'd3);         // Four cycles per SCLK level
        run_bytes(4, 4);
        write_cfg(1'b0, 8'd0);
        write_cfg(1'b1, 8'd1);         // Burst on with the queue kept full
        run_bytes(6, 1);
        write_cfg(1'b1, 8'd0);
        run_backpressure();

        assert (credit_seen == sent_q.size())
            else report_mismatch("tx_credit pulses", sent_q.size(), credit_seen);
        if (dut.chk.err_cnt == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_sim("A timing assertion in the checker failed near the end");
        end
    end

endmodule

// File: sim/spi_master_checker.sv
`timescale 1ns/1ns

module spi_master_checker #(
    parameter int TX_DEPTH   = 4,
    parameter int RX_CREDITS = 2
) (
    input logic clk,
    input logic rst,
    input logic ss,
    input logic sclk,
    input logic mosi,
    input logic tx_valid,
    input logic tx_credit,
    input logic rx_valid,
    input logic rx_credit
);

    int tx_out  = 0;                   // Pushes not yet returned as credit
    int rx_held = 0;                   // Deliveries the host still holds
    int err_cnt = 0;                   // Failed assertions so far

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_out  <= 0;
            rx_held <= 0;
        end else begin
            tx_out  <= tx_out + int'(tx_valid) - int'(tx_credit);
            rx_held <= rx_held + int'(rx_valid) - int'(rx_credit);
        end
    end

    // Mode 3 idle level
    sclk_idle_high: assert property (@(posedge clk) disable iff (rst) ss |-> sclk)
        else begin
            $error("SCLK low while SS is high");
            err_cnt++;
        end

    // MOSI only moves with the falling SCLK
    mosi_stable: assert property (@(posedge clk) disable iff (rst)
        (sclk && $past(sclk)) |-> $stable(mosi))
        else begin
            $error("MOSI changed while SCLK was high");
            err_cnt++;
        end

    // No delivery into a host without free slots
    rx_needs_credit: assert property (@(posedge clk) disable iff (rst)
        rx_valid |-> (rx_held < RX_CREDITS))
        else begin
            $error("rx_valid with no receive credit left");
            err_cnt++;
        end

    // Credits come back only for pushes still held in the queue
    tx_within_depth: assert property (@(posedge clk) disable iff (rst)
        (tx_out >= 0) && (tx_out <= TX_DEPTH))
        else begin
            $error("Outstanding push count outside 0 to TX_DEPTH");
            err_cnt++;
        end

endmodule

bind spi_master_top spi_master_checker #(
    .TX_DEPTH   (TX_DEPTH),
    .RX_CREDITS (RX_CREDITS)
) chk (
    .clk       (clk),
    .rst       (rst),
    .ss        (ss),
    .sclk      (sclk),
    .mosi      (mosi),
    .tx_valid  (tx_valid),
    .tx_credit (tx_credit),
    .rx_valid  (rx_valid),
    .rx_credit (rx_credit)
);

// File: sim/spi_slave_model.sv
`timescale 1ns/1ns

module spi_slave_model (
    input  logic sclk,
    input  logic mosi,
    input  logic ss,
    output logic miso
);

    spi_pkg::byte_t got_q[$];          // Bytes seen on MOSI, oldest first
    spi_pkg::byte_t tx_sh;             // Reply being shifted out
    spi_pkg::byte_t rx_sh;             // Byte being assembled from MOSI
    int             bit_n;             // Bits sampled in the current byte
    int             reply_n;           // Replies sent so far

    initial begin
        miso    = 1'b0;
        tx_sh   = '0;
        rx_sh   = '0;
        bit_n   = 0;
        reply_n = 0;
    end

    // New select period always starts at bit 7
    always @(negedge ss) begin
        bit_n = 0;
    end

    // Mode 3, drive on the falling edge
    always @(negedge sclk) begin
        if (!ss) begin
            if (bit_n == 0) begin
                tx_sh = spi_pkg::byte_t'(8'hA5 + reply_n);  // Scripted reply
            end
            miso <= tx_sh[7];
            tx_sh = {tx_sh[6:0], 1'b0};
        end
    end

    // Sample MOSI on the rising edge, MSB first
    always @(posedge sclk) begin
        if (!ss) begin
            rx_sh = {rx_sh[6:0], mosi};
            bit_n++;
            if (bit_n == 8) begin
                got_q.push_back(rx_sh);
                bit_n = 0;              // Burst keeps SS low across bytes
                reply_n++;
            end
        end
    end

endmodule

// File: rtl/spi_master_top.sv
`timescale 1ns/1ns

module spi_master_top #(
    parameter int TX_DEPTH   = 4,      // Transmit entries, also the host's starting credit
    parameter int RX_CREDITS = 2       // Receive slots granted at reset
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           tx_valid,
    input  spi_pkg::byte_t tx_data,
    output logic           tx_credit,
    output logic           rx_valid,
    output spi_pkg::byte_t rx_data,
    input  logic           rx_credit,
    input  logic           cfg_we,
    input  logic           cfg_addr,
    input  spi_pkg::byte_t cfg_wdata,
    output spi_pkg::byte_t cfg_rdata,
    output logic           sclk,
    output logic           mosi,
    input  logic           miso,
    output logic           ss
);

    spi_pkg::div_t  sclk_div;          // Config to engine
    logic           burst;
    spi_pkg::byte_t q_data;            // Queue to engine
    logic           q_empty;
    logic           q_pop;
    logic           byte_done;         // Engine to receive path
    spi_pkg::byte_t byte_rx;
    logic           rx_room;

    spi_cfg_regs u_cfg (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .sclk_div  (sclk_div),
        .burst     (burst)
    );

    spi_tx_queue #(.TX_DEPTH(TX_DEPTH)) u_txq (
        .clk       (clk),
        .rst       (rst),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .q_pop     (q_pop),
        .q_data    (q_data),
        .q_empty   (q_empty),
        .tx_credit (tx_credit)
    );

    spi_byte_engine u_eng (
        .clk       (clk),
        .rst       (rst),
        .q_data    (q_data),
        .q_empty   (q_empty),
        .rx_room   (rx_room),
        .sclk_div  (sclk_div),
        .burst     (burst),
        .miso      (miso),
        .q_pop     (q_pop),
        .byte_done (byte_done),
        .byte_rx   (byte_rx),
        .sclk      (sclk),
        .mosi      (mosi),
        .ss        (ss)
    );

    spi_rx_return #(.RX_CREDITS(RX_CREDITS)) u_rx (
        .clk       (clk),
        .rst       (rst),
        .byte_done (byte_done),
        .byte_rx   (byte_rx),
        .rx_credit (rx_credit),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_room   (rx_room)
    );

endmodule

// File: rtl/spi_rx_return.sv
`timescale 1ns/1ns

module spi_rx_return #(
    parameter int RX_CREDITS = 2
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           byte_done,  // Engine finished a byte
    input  spi_pkg::byte_t byte_rx,
    input  logic           rx_credit,  // Host freed one slot
    output logic           rx_valid,
    output spi_pkg::byte_t rx_data,
    output logic           rx_room     // At least one slot free at the host
);

    spi_pkg::credit_t credits;         // Free host slots

    assign rx_room = (credits != '0);

    // Received byte toward the host, no reset on payload
    always_ff @(posedge clk) begin
        if (byte_done) begin
            rx_data <= byte_rx;
        end
    end

    // Delivery strobe, one cycle after byte_done
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= byte_done;
        end
    end

    // Credit count
    // Taken on the same edge that raises rx_valid, so the engine
    // sees the lower count before its next start check
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= spi_pkg::credit_t'(RX_CREDITS);   // Grant at reset
        end else begin
            case ({rx_credit, byte_done})
                2'b10:   credits <= credits + 1'b1;      // Return only
                2'b01:   credits <= credits - 1'b1;      // Delivery only
                default: credits <= credits;             // Both or neither
            endcase
        end
    end

endmodule

// File: rtl/spi_byte_engine.sv
`timescale 1ns/1ns

module spi_byte_engine (
    input  logic           clk,
    input  logic           rst,
    input  spi_pkg::byte_t q_data,     // Head of the transmit queue
    input  logic           q_empty,
    input  logic           rx_room,    // Receive credit available
    input  spi_pkg::div_t  sclk_div,
    input  logic           burst,
    input  logic           miso,
    output logic           q_pop,      // Also the start of a byte
    output logic           byte_done,  // One cycle after the eighth SCLK rise
    output spi_pkg::byte_t byte_rx,
    output logic           sclk,
    output logic           mosi,
    output logic           ss          // Active low select
);

    spi_pkg::eng_state_e state;
    spi_pkg::div_t       half_cnt;     // Cycles spent in the current SCLK level
    spi_pkg::div_t       div_l;        // Divider copy for the byte in flight
    logic                burst_l;      // Burst copy for the byte in flight
    logic [2:0]          bit_cnt;      // Bit position, 0 is the MSB
    spi_pkg::byte_t      shreg;        // TX bits leave at the top, RX bits enter at the bottom
    logic                start_ok;
    logic                half_end;

    // Start rule, data waiting and somewhere to put the reply
    assign start_ok = !q_empty && rx_room;
    assign half_end = (half_cnt == div_l);

    // New byte from IDLE, or back to back while still selected in a burst
    assign q_pop = start_ok &&
                   ((state == spi_pkg::IDLE) ||
                    ((state == spi_pkg::DESELECT) && !ss && burst_l));

    assign byte_rx = shreg;            // Complete from the cycle byte_done is high

    // Shift register, one for both directions
    always_ff @(posedge clk) begin
        if (q_pop) begin
            shreg <= q_data;
        end else if ((state == spi_pkg::SHIFT_LOW) && half_end) begin
            shreg <= {shreg[6:0], miso};   // Sample as SCLK rises
        end
    end

    // Engine FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= spi_pkg::IDLE;
            half_cnt  <= '0;
            div_l     <= '0;
            burst_l   <= 1'b0;
            bit_cnt   <= '0;
            sclk      <= 1'b1;             // Mode 3 idles high
            mosi      <= 1'b0;
            ss        <= 1'b1;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (q_pop) begin
                // Settings are frozen here for the whole byte
                state    <= spi_pkg::SELECT;
                ss       <= 1'b0;
                div_l    <= sclk_div;
                burst_l  <= burst;
                half_cnt <= '0;
                bit_cnt  <= '0;
            end else begin
                case (state)
                    spi_pkg::IDLE: begin
                        half_cnt <= '0;    // Wait for the start rule
                    end
                    spi_pkg::SELECT: begin
                        if (half_end) begin
                            state    <= spi_pkg::SHIFT_LOW;
                            sclk     <= 1'b0;
                            mosi     <= shreg[7];  // First bit on the first fall
                            half_cnt <= '0;
                        end else begin
                            half_cnt <= half_cnt + 1'b1;
                        end
                    end
                    spi_pkg::SHIFT_LOW: begin
                        if (half_end) begin
                            state    <= spi_pkg::SHIFT_HIGH;
                            sclk     <= 1'b1;
                            half_cnt <= '0;
                            if (bit_cnt == 3'd7) begin
                                byte_done <= 1'b1; // Last bit just sampled
                            end
                        end else begin
                            half_cnt <= half_cnt + 1'b1;
                        end
                    end
                    spi_pkg::SHIFT_HIGH: begin
                        if (half_end) begin
                            half_cnt <= '0;
                            if (bit_cnt == 3'd7) begin
                                // Receive credit has settled by the next cycle
                                state <= spi_pkg::DESELECT;
                            end else begin
                                state   <= spi_pkg::SHIFT_LOW;
                                bit_cnt <= bit_cnt + 1'b1;
                                sclk    <= 1'b0;
                                mosi    <= shreg[7];
                            end
                        end else begin
                            half_cnt <= half_cnt + 1'b1;
                        end
                    end
                    spi_pkg::DESELECT: begin
                        if (!ss) begin
                            ss       <= 1'b1;      // No burst continue this cycle
                            half_cnt <= '0;
                        end else if (half_end) begin
                            state <= spi_pkg::IDLE; // SS was high for d+1 cycles
                        end else begin
                            half_cnt <= half_cnt + 1'b1;
                        end
                    end
                    default: begin
                        state <= spi_pkg::IDLE;
                        ss    <= 1'b1;
                        sclk  <= 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

// File: rtl/spi_tx_queue.sv
`timescale 1ns/1ns

module spi_tx_queue #(
    parameter int TX_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             tx_valid,   // Host push, only while it holds a credit
    input  spi_pkg::byte_t   tx_data,
    input  logic             q_pop,      // Engine takes the head entry
    output spi_pkg::byte_t   q_data,
    output logic             q_empty,
    output logic             tx_credit   // One pulse per popped entry
);

    // Pointer width, at least one bit for a single entry queue
    localparam int PW = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;

    spi_pkg::byte_t   mem [TX_DEPTH];   // Byte storage
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    spi_pkg::credit_t count;            // Entries held
    logic             full;
    logic             push;
    logic             pop;

    // Wrap a pointer at the last entry, depth need not be a power of two
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        logic [PW-1:0] nxt;
        if (ptr == PW'(TX_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign full    = (count == spi_pkg::credit_t'(TX_DEPTH));
    assign q_empty = (count == '0);
    assign push    = tx_valid && !full;     // Credits keep the host from hitting full
    assign pop     = q_pop && !q_empty;
    assign q_data  = mem[rd_ptr];           // Head entry seen by the engine

    // Storage write
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= tx_data;
        end
    end

    // Pointers, fill count and the credit pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            tx_credit <= 1'b0;
        end else begin
            tx_credit <= pop;               // Freed slot goes back to the host
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Idle or push with pop
            endcase
        end
    end

endmodule

// File: rtl/spi_cfg_regs.sv
`timescale 1ns/1ns

module spi_cfg_regs (
    input  logic           clk,
    input  logic           rst,
    input  logic           cfg_we,
    input  logic           cfg_addr,    // 0 divider, 1 burst
    input  spi_pkg::byte_t cfg_wdata,
    output spi_pkg::byte_t cfg_rdata,
    output spi_pkg::div_t  sclk_div,
    output logic           burst
);

    logic wr_div;   // Write strobe for the divider
    logic wr_burst; // Write strobe for the burst flag

    // Address decode
    assign wr_div   = cfg_we && (cfg_addr == 1'b0);
    assign wr_burst = cfg_we && (cfg_addr == 1'b1);

    // Divider register
    // The engine copies it when a byte starts, so a write here
    // never disturbs the byte already on the wire
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sclk_div <= '0;             // Fastest SCLK after reset
        end else if (wr_div) begin
            sclk_div <= cfg_wdata;
        end
    end

    // Burst flag, bit 0 of address 1
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            burst <= 1'b0;              // One byte per select by default
        end else if (wr_burst) begin
            burst <= cfg_wdata[0];
        end
    end

    // Readback follows the address with no register stage
    always_comb begin
        if (cfg_addr) begin
            cfg_rdata = {7'b0, burst};  // Upper bits read as zero
        end else begin
            cfg_rdata = sclk_div;
        end
    end

endmodule

// File: rtl/spi_pkg.sv
package spi_pkg;

    // One data byte on MOSI or MISO
    typedef logic [7:0] byte_t;

    // SCLK half period setting
    // A value d holds each SCLK level for d+1 clk cycles
    typedef logic [7:0] div_t;

    // Credit and fill counters, room for depths up to 15
    typedef logic [3:0] credit_t;

    // Byte engine FSM
    typedef enum logic [2:0] {
        IDLE,       // SS high, waiting for data and receive room
        SELECT,     // SS low, SCLK held high before the first fall
        SHIFT_LOW,  // SCLK low, MOSI carries the current bit
        SHIFT_HIGH, // SCLK high, MISO was sampled on the rise
        DESELECT    // End of byte, burst continue or SS release
    } eng_state_e;

endpackage
